// File: sim.f
bus_pkg.sv
nmi_if.sv
bus_arbiter.sv
nmi_regslice.sv
addr_decoder.sv
scratch_ram.sv
soc_bus.sv
bus_checker.sv
tb_soc_bus.sv

// File: Makefile
RTL = bus_pkg.sv nmi_if.sv bus_arbiter.sv nmi_regslice.sv addr_decoder.sv \
      scratch_ram.sv soc_bus.sv

.PHONY: all build run lint clean

all: build run

build:
	verilator --binary --timing --assert -f sim.f --top-module tb_soc_bus -Mdir obj_dir

run:
	./obj_dir/Vtb_soc_bus | tee /dev/stderr | grep -q '^>>> PASS$$'

lint:
	verilator --lint-only -Wall $(RTL) --top-module soc_bus

clean:
	rm -rf obj_dir

// File: tb_soc_bus.sv
/*
 * system bus testbench
 * directed tests over RAM, peripheral routing, error response,
 * arbitration and back-pressure, with native and APB models
 */

`timescale 1ns/1ps

module tb_soc_bus;
  import bus_pkg::*;

  localparam int CYCLE     = 100;
  localparam int NUM_TESTS = 6;

  logic              clk_i = 1'b0;
  logic              rst_i = 1'b1;
  logic              core_valid_i = 1'b0;
  logic [ADDR_W-1:0] core_addr_i = '0;
  logic [DATA_W-1:0] core_wdata_i = '0;
  logic [STRB_W-1:0] core_wstrb_i = '0;
  logic              core_ready_o;
  logic [DATA_W-1:0] core_rdata_o;
  logic              dma_valid_i = 1'b0;
  logic [ADDR_W-1:0] dma_addr_i = '0;
  logic [DATA_W-1:0] dma_wdata_i = '0;
  logic [STRB_W-1:0] dma_wstrb_i = '0;
  logic              dma_ready_o;
  logic [DATA_W-1:0] dma_rdata_o;
  logic              natv_valid_o;
  logic [ADDR_W-1:0] natv_addr_o;
  logic [DATA_W-1:0] natv_wdata_o;
  logic [STRB_W-1:0] natv_wstrb_o;
  logic              natv_ready_i = 1'b0;
  logic [DATA_W-1:0] natv_rdata_i = '0;
  logic              apb_valid_o;
  logic [ADDR_W-1:0] apb_addr_o;
  logic [DATA_W-1:0] apb_wdata_o;
  logic [STRB_W-1:0] apb_wstrb_o;
  logic              apb_ready_i = 1'b0;
  logic [DATA_W-1:0] apb_rdata_i = '0;

  // peripheral model state
  int                natv_cnt = 0;
  int                natv_hits = 0;
  logic [ADDR_W-1:0] natv_last = '0;
  logic [DATA_W-1:0] natv_last_wdata = '0;
  logic [STRB_W-1:0] natv_last_wstrb = '0;
  int                apb_cnt = 0;
  int                apb_hits = 0;
  int                apb_delay = 3;
  logic [ADDR_W-1:0] apb_last = '0;
  logic [DATA_W-1:0] apb_last_wdata = '0;
  logic [STRB_W-1:0] apb_last_wstrb = '0;

  integer            seed = 57;
  logic [DATA_W-1:0] shadow [RAM_WORDS];

  soc_bus dut (.*);

  initial begin
    forever #(CYCLE / 2) clk_i = ~clk_i;
  end

  // native target, answers two cycles after valid
  always @(negedge clk_i) begin
    if (natv_ready_i) begin
      natv_ready_i <= 1'b0;
      natv_cnt     <= 0;
    end else if (natv_valid_o) begin
      if (natv_cnt == 1) begin
        natv_ready_i    <= 1'b1;
        natv_rdata_i    <= natv_addr_o ^ 32'h5A5A_0000;
        natv_hits       <= natv_hits + 1;
        natv_last       <= natv_addr_o;
        natv_last_wdata <= natv_wdata_o;
        natv_last_wstrb <= natv_wstrb_o;
      end else begin
        natv_cnt <= natv_cnt + 1;
      end
    end
  end

  // APB target with programmable delay
  always @(negedge clk_i) begin
    if (apb_ready_i) begin
      apb_ready_i <= 1'b0;
      apb_cnt     <= 0;
    end else if (apb_valid_o) begin
      if (apb_cnt >= apb_delay - 1) begin
        apb_ready_i    <= 1'b1;
        apb_rdata_i    <= apb_addr_o ^ 32'hA5A5_0000;
        apb_hits       <= apb_hits + 1;
        apb_last       <= apb_addr_o;
        apb_last_wdata <= apb_wdata_o;
        apb_last_wstrb <= apb_wstrb_o;
      end else begin
        apb_cnt <= apb_cnt + 1;
      end
    end
  end

  initial begin
    #(NUM_TESTS * 40 * CYCLE + 20 * CYCLE);
    $display("watchdog expired, a transfer never completed");
    $display(">>> FAIL");
    $fatal(1);
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error: %s expected %h actual %h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] ram_addr(input int idx);
    return {RAM_BASE, 24'(idx * 4)};
  endfunction

  // one transfer on the core or DMA port, called on a falling edge
  task automatic bus_access(input bit use_dma, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] strb,
                            output logic [31:0] rdata, output time done_t);
    bit got;
    got = 1'b0;
    if (use_dma) begin
      dma_valid_i = 1'b1;
      dma_addr_i  = addr;
      dma_wdata_i = wdata;
      dma_wstrb_i = strb;
    end else begin
      core_valid_i = 1'b1;
      core_addr_i  = addr;
      core_wdata_i = wdata;
      core_wstrb_i = strb;
    end
    while (!got) begin
      @(negedge clk_i);
      if (use_dma ? dma_ready_o : core_ready_o) begin
        got    = 1'b1;
        rdata  = use_dma ? dma_rdata_o : core_rdata_o;
        done_t = $time;
      end
    end
    @(negedge clk_i);
    if (use_dma) dma_valid_i = 1'b0;
    else core_valid_i = 1'b0;
  endtask

  task automatic test_reset();
    rst_i = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      check("reset_hold", 4'b0, {core_ready_o, dma_ready_o, natv_valid_o, apb_valid_o});
    end
    rst_i = 1'b0;
    repeat (2) begin
      @(negedge clk_i);
      check("reset_after", 4'b0, {core_ready_o, dma_ready_o, natv_valid_o, apb_valid_o});
    end
  endtask

  task automatic test_ram();
    logic [31:0] w;
    logic [31:0] rd;
    time         t;
    for (int i = 0; i < 6; i++) begin
      w = $random(seed);
      bus_access(1'b0, ram_addr(i), w, 4'hF, rd, t);
      shadow[i] = w;
    end
    // partial strobes over words already written
    w = $random(seed);
    bus_access(1'b0, ram_addr(1), w, 4'b0101, rd, t);
    shadow[1] = merge_bytes(shadow[1], w, 4'b0101);
    w = $random(seed);
    bus_access(1'b1, ram_addr(4), w, 4'b1000, rd, t);
    shadow[4] = merge_bytes(shadow[4], w, 4'b1000);
    for (int i = 0; i < 6; i++) begin
      bus_access(1'b0, ram_addr(i), '0, 4'h0, rd, t);
      check("ram_rw", shadow[i], rd);
    end
  endtask

  task automatic test_routing();
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] rd;
    time         t;
    int          n0;
    int          a0;
    n0 = natv_hits;
    a0 = apb_hits;
    a  = {NATV_BASE, 24'h00_0124};
    bus_access(1'b0, a, '0, 4'h0, rd, t);
    check("route_natv_data", a ^ 32'h5A5A_0000, rd);
    check("route_natv_addr", a, natv_last);
    check("route_natv_hits", n0 + 1, natv_hits);
    check("route_natv_apb", a0, apb_hits);
    a = {APB_BASE, 24'h00_0308};
    bus_access(1'b0, a, '0, 4'h0, rd, t);
    check("route_apb_data", a ^ 32'hA5A5_0000, rd);
    check("route_apb_addr", a, apb_last);
    a = {FLASH_BASE, 24'h01_0040};
    bus_access(1'b0, a, '0, 4'h0, rd, t);
    check("route_flash_data", a ^ 32'hA5A5_0000, rd);
    check("route_flash_addr", a, apb_last);
    check("route_apb_hits", a0 + 2, apb_hits);
    check("route_apb_natv", n0 + 1, natv_hits);
    // write payload and strobes reach the peripheral ports
    w = $random(seed);
    a = {NATV_BASE, 24'h00_0200};
    bus_access(1'b0, a, w, 4'b0110, rd, t);
    check("route_natv_wdata", w, natv_last_wdata);
    check("route_natv_wstrb", 4'b0110, natv_last_wstrb);
    w = $random(seed);
    a = {APB_BASE, 24'h00_0310};
    bus_access(1'b1, a, w, 4'b1001, rd, t);
    check("route_apb_wdata", w, apb_last_wdata);
    check("route_apb_wstrb", 4'b1001, apb_last_wstrb);
  endtask

  task automatic test_unmapped();
    logic [31:0] rd;
    time         t;
    int          n0;
    int          a0;
    n0 = natv_hits;
    a0 = apb_hits;
    bus_access(1'b0, 32'h4000_0010, '0, 4'h0, rd, t);
    check("unmapped_data", ERR_WORD, rd);
    check("unmapped_natv", n0, natv_hits);
    check("unmapped_apb", a0, apb_hits);
  endtask

  task automatic test_priority();
    logic [31:0] wc;
    logic [31:0] wd;
    logic [31:0] rc;
    logic [31:0] rdd;
    time         tc;
    time         td;
    wc = $random(seed);
    wd = $random(seed);
    bus_access(1'b0, ram_addr(10), wc, 4'hF, rc, tc);
    bus_access(1'b1, ram_addr(11), wd, 4'hF, rdd, td);
    fork
      bus_access(1'b0, ram_addr(10), '0, 4'h0, rc, tc);
      bus_access(1'b1, ram_addr(11), '0, 4'h0, rdd, td);
    join
    check("prio_core_data", wc, rc);
    check("prio_dma_data", wd, rdd);
    check("prio_dma_first", 1, td < tc);
  endtask

  task automatic test_backpressure();
    logic [31:0] ac;
    logic [31:0] ad;
    logic [31:0] rc;
    logic [31:0] rdd;
    time         tc;
    time         td;
    int          a0;
    apb_delay = 10;
    a0 = apb_hits;
    ac = {APB_BASE, 24'h00_0500};
    ad = {FLASH_BASE, 24'h00_0504};
    fork
      bus_access(1'b0, ac, '0, 4'h0, rc, tc);
      begin
        repeat (2) @(negedge clk_i);
        bus_access(1'b1, ad, '0, 4'h0, rdd, td);
      end
    join
    check("bp_core_data", ac ^ 32'hA5A5_0000, rc);
    check("bp_dma_data", ad ^ 32'hA5A5_0000, rdd);
    check("bp_dma_after", 1, td > tc);
    check("bp_apb_count", 2, apb_hits - a0);
    apb_delay = 3;
  endtask

  initial begin
    test_reset();
    test_ram();
    test_routing();
    test_unmapped();
    test_priority();
    test_backpressure();
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: bus_checker.sv
/*
 * bus protocol checker
 * handshake, grant and request stability assertions,
 * bound to the system bus top level
 */

`timescale 1ns/1ps

module bus_checker (
  input logic                       clk_i,
  input logic                       rst_i,
  input logic                       core_valid_i,
  input logic [bus_pkg::ADDR_W-1:0] core_addr_i,
  input logic [bus_pkg::DATA_W-1:0] core_wdata_i,
  input logic [bus_pkg::STRB_W-1:0] core_wstrb_i,
  input logic                       core_ready_i,
  input logic                       dma_valid_i,
  input logic [bus_pkg::ADDR_W-1:0] dma_addr_i,
  input logic [bus_pkg::DATA_W-1:0] dma_wdata_i,
  input logic [bus_pkg::STRB_W-1:0] dma_wstrb_i,
  input logic                       dma_ready_i
);
  import bus_pkg::*;

  // a slave answers only a pending request
  a_core_ready_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    core_ready_i |-> core_valid_i) else $error("core ready without valid");
  a_dma_ready_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    dma_ready_i |-> dma_valid_i) else $error("dma ready without valid");

  // one transfer on the bus at a time
  a_one_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    !(core_ready_i && dma_ready_i)) else $error("core and dma ready together");

  // request fields held while waiting
  a_core_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    core_valid_i && !core_ready_i |=> $stable({core_addr_i, core_wdata_i, core_wstrb_i}))
    else $error("core request changed while waiting");
  a_dma_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    dma_valid_i && !dma_ready_i |=> $stable({dma_addr_i, dma_wdata_i, dma_wstrb_i}))
    else $error("dma request changed while waiting");

endmodule

bind soc_bus bus_checker u_checker (
  .clk_i (clk_i), .rst_i (rst_i),
  .core_valid_i (core_valid_i), .core_addr_i (core_addr_i),
  .core_wdata_i (core_wdata_i), .core_wstrb_i (core_wstrb_i),
  .core_ready_i (core_ready_o),
  .dma_valid_i (dma_valid_i), .dma_addr_i (dma_addr_i),
  .dma_wdata_i (dma_wdata_i), .dma_wstrb_i (dma_wstrb_i),
  .dma_ready_i (dma_ready_o)
);

// File: soc_bus.sv
/*
 * SoC system bus top level
 * core and DMA masters through arbiter, register slice and
 * address decoder to scratch RAM, native and APB targets
 */

`timescale 1ns/1ps

module soc_bus (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // core master
  input  logic                        core_valid_i,
  input  logic [bus_pkg::ADDR_W-1:0]  core_addr_i,
  input  logic [bus_pkg::DATA_W-1:0]  core_wdata_i,
  input  logic [bus_pkg::STRB_W-1:0]  core_wstrb_i,
  output logic                        core_ready_o,
  output logic [bus_pkg::DATA_W-1:0]  core_rdata_o,
  // DMA master
  input  logic                        dma_valid_i,
  input  logic [bus_pkg::ADDR_W-1:0]  dma_addr_i,
  input  logic [bus_pkg::DATA_W-1:0]  dma_wdata_i,
  input  logic [bus_pkg::STRB_W-1:0]  dma_wstrb_i,
  output logic                        dma_ready_o,
  output logic [bus_pkg::DATA_W-1:0]  dma_rdata_o,
  // native peripheral target
  output logic                        natv_valid_o,
  output logic [bus_pkg::ADDR_W-1:0]  natv_addr_o,
  output logic [bus_pkg::DATA_W-1:0]  natv_wdata_o,
  output logic [bus_pkg::STRB_W-1:0]  natv_wstrb_o,
  input  logic                        natv_ready_i,
  input  logic [bus_pkg::DATA_W-1:0]  natv_rdata_i,
  // APB bridge target
  output logic                        apb_valid_o,
  output logic [bus_pkg::ADDR_W-1:0]  apb_addr_o,
  output logic [bus_pkg::DATA_W-1:0]  apb_wdata_o,
  output logic [bus_pkg::STRB_W-1:0]  apb_wstrb_o,
  input  logic                        apb_ready_i,
  input  logic [bus_pkg::DATA_W-1:0]  apb_rdata_i
);

  nmi_if core_if ();
  nmi_if dma_if ();
  nmi_if arb_if ();
  nmi_if slc_if ();
  nmi_if ram_if ();

  // plain master ports onto their bundles
  assign core_if.valid = core_valid_i;
  assign core_if.addr  = core_addr_i;
  assign core_if.wdata = core_wdata_i;
  assign core_if.wstrb = core_wstrb_i;
  assign core_ready_o  = core_if.ready;
  assign core_rdata_o  = core_if.rdata;

  assign dma_if.valid  = dma_valid_i;
  assign dma_if.addr   = dma_addr_i;
  assign dma_if.wdata  = dma_wdata_i;
  assign dma_if.wstrb  = dma_wstrb_i;
  assign dma_ready_o   = dma_if.ready;
  assign dma_rdata_o   = dma_if.rdata;

  bus_arbiter u_arbiter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .core_i   (core_if.slave),
    .dma_i    (dma_if.slave),
    .shared_o (arb_if.master)
  );

  // breaks the path between arbitration and decode
  nmi_regslice u_regslice (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .up_i  (arb_if.slave),
    .dn_o  (slc_if.master)
  );

  addr_decoder u_decoder (
    .slc_i        (slc_if.slave),
    .ram_o        (ram_if.master),
    .natv_valid_o (natv_valid_o),
    .natv_addr_o  (natv_addr_o),
    .natv_wdata_o (natv_wdata_o),
    .natv_wstrb_o (natv_wstrb_o),
    .natv_ready_i (natv_ready_i),
    .natv_rdata_i (natv_rdata_i),
    .apb_valid_o  (apb_valid_o),
    .apb_addr_o   (apb_addr_o),
    .apb_wdata_o  (apb_wdata_o),
    .apb_wstrb_o  (apb_wstrb_o),
    .apb_ready_i  (apb_ready_i),
    .apb_rdata_i  (apb_rdata_i)
  );

  scratch_ram u_ram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus_i (ram_if.slave)
  );

endmodule

// File: scratch_ram.sv
/*
 * on-chip scratch RAM
 * word array with byte strobe writes, ready and read data
 * registered one cycle after valid
 */

`timescale 1ns/1ps

module scratch_ram (
  input  logic clk_i,
  input  logic rst_i,
  nmi_if.slave bus_i
);
  import bus_pkg::*;

  logic [DATA_W-1:0] mem_q [RAM_WORDS];
  logic [RAM_AW-1:0] idx;
  logic              access;
  logic              ready_q;
  logic [DATA_W-1:0] rdata_q;

  // word index from the byte address
  assign idx = bus_i.addr[RAM_AW+1:2];

  // a held valid is served once, skip the cycle after ready
  assign access = bus_i.valid && !ready_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (bus_i.wstrb[b]) begin
          mem_q[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
      end
      rdata_q <= mem_q[idx];
    end
  end

  assign bus_i.ready = ready_q;
  assign bus_i.rdata = rdata_q;

endmodule

// File: addr_decoder.sv
/*
 * address decoder
 * steers the sliced request to scratch RAM, native or APB
 * target by the top address byte, unmapped gets an error word
 */

`timescale 1ns/1ps

module addr_decoder (
  nmi_if.slave                        slc_i,
  nmi_if.master                       ram_o,
  output logic                        natv_valid_o,
  output logic [bus_pkg::ADDR_W-1:0]  natv_addr_o,
  output logic [bus_pkg::DATA_W-1:0]  natv_wdata_o,
  output logic [bus_pkg::STRB_W-1:0]  natv_wstrb_o,
  input  logic                        natv_ready_i,
  input  logic [bus_pkg::DATA_W-1:0]  natv_rdata_i,
  output logic                        apb_valid_o,
  output logic [bus_pkg::ADDR_W-1:0]  apb_addr_o,
  output logic [bus_pkg::DATA_W-1:0]  apb_wdata_o,
  output logic [bus_pkg::STRB_W-1:0]  apb_wstrb_o,
  input  logic                        apb_ready_i,
  input  logic [bus_pkg::DATA_W-1:0]  apb_rdata_i
);
  import bus_pkg::*;

  logic [7:0] top_byte;
  target_e    tgt;

  assign top_byte = slc_i.addr[ADDR_W-1:ADDR_W-8];

  always_comb begin
    case (top_byte)
      RAM_BASE:             tgt = TGT_RAM;
      NATV_BASE:            tgt = TGT_NATV;
      APB_BASE, FLASH_BASE: tgt = TGT_APB;
      default:              tgt = TGT_NONE;
    endcase
  end

  // only the selected target sees valid
  assign ram_o.valid  = slc_i.valid && (tgt == TGT_RAM);
  assign ram_o.addr   = slc_i.addr;
  assign ram_o.wdata  = slc_i.wdata;
  assign ram_o.wstrb  = slc_i.wstrb;

  assign natv_valid_o = slc_i.valid && (tgt == TGT_NATV);
  assign natv_addr_o  = slc_i.addr;
  assign natv_wdata_o = slc_i.wdata;
  assign natv_wstrb_o = slc_i.wstrb;

  assign apb_valid_o  = slc_i.valid && (tgt == TGT_APB);
  assign apb_addr_o   = slc_i.addr;
  assign apb_wdata_o  = slc_i.wdata;
  assign apb_wstrb_o  = slc_i.wstrb;

  // response from the selected target
  always_comb begin
    slc_i.ready = 1'b0;
    slc_i.rdata = '0;
    case (tgt)
      TGT_RAM: begin
        slc_i.ready = ram_o.valid && ram_o.ready;
        slc_i.rdata = ram_o.rdata;
      end
      TGT_NATV: begin
        slc_i.ready = natv_valid_o && natv_ready_i;
        slc_i.rdata = natv_rdata_i;
      end
      TGT_APB: begin
        slc_i.ready = apb_valid_o && apb_ready_i;
        slc_i.rdata = apb_rdata_i;
      end
      // nobody home, answer at once so the bus cannot hang
      default: begin
        slc_i.ready = slc_i.valid;
        slc_i.rdata = ERR_WORD;
      end
    endcase
  end

endmodule

// File: nmi_regslice.sv
/*
 * one entry register slice
 * registers the request on the way down and the response
 * on the way back, one transfer in flight at a time
 */

`timescale 1ns/1ps

module nmi_regslice (
  input  logic  clk_i,
  input  logic  rst_i,
  nmi_if.slave  up_i,
  nmi_if.master dn_o
);
  import bus_pkg::*;

  slice_state_e      state_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] wstrb_q;
  logic [DATA_W-1:0] rdata_q;
  logic              capture;
  logic              served;

  assign capture = (state_q == SL_IDLE) && up_i.valid;
  assign served  = (state_q == SL_BUSY) && dn_o.ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= SL_IDLE;
    end else begin
      case (state_q)
        SL_IDLE: if (capture) state_q <= SL_BUSY;
        SL_BUSY: if (served) state_q <= SL_RESP;
        // single pulse upstream, then back to idle
        SL_RESP: state_q <= SL_IDLE;
        default: state_q <= SL_IDLE;
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk_i) begin
    if (capture) begin
      addr_q  <= up_i.addr;
      wdata_q <= up_i.wdata;
      wstrb_q <= up_i.wstrb;
    end
    if (served) begin
      rdata_q <= dn_o.rdata;
    end
  end

  // downstream request held until served
  assign dn_o.valid = (state_q == SL_BUSY);
  assign dn_o.addr  = addr_q;
  assign dn_o.wdata = wdata_q;
  assign dn_o.wstrb = wstrb_q;

  assign up_i.ready = (state_q == SL_RESP);
  assign up_i.rdata = (state_q == SL_RESP) ? rdata_q : '0;

endmodule

// File: bus_arbiter.sv
/*
 * two master bus arbiter
 * locks core or DMA onto the shared path until its transfer
 * completes, DMA wins whenever it is requesting
 */

`timescale 1ns/1ps

module bus_arbiter (
  input  logic  clk_i,
  input  logic  rst_i,
  nmi_if.slave  core_i,
  nmi_if.slave  dma_i,
  nmi_if.master shared_o
);
  import bus_pkg::*;

  logic lock_q;
  logic lock_d;
  logic dma_sel_q;
  logic dma_sel_d;
  logic grant_core;
  logic grant_dma;

  // grant on a free bus, release on the ready of the locked master
  always_comb begin
    lock_d    = lock_q;
    dma_sel_d = dma_sel_q;
    if (!lock_q) begin
      if (dma_i.valid) begin
        lock_d    = 1'b1;
        dma_sel_d = 1'b1;
      end else if (core_i.valid) begin
        lock_d    = 1'b1;
        dma_sel_d = 1'b0;
      end
    end else if (shared_o.ready) begin
      lock_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q    <= 1'b0;
      dma_sel_q <= 1'b0;
    end else begin
      lock_q    <= lock_d;
      dma_sel_q <= dma_sel_d;
    end
  end

  assign grant_core = lock_q && !dma_sel_q;
  assign grant_dma  = lock_q && dma_sel_q;

  // request mux, valid only passes once the lock is set
  assign shared_o.valid = grant_dma ? dma_i.valid : (grant_core && core_i.valid);
  assign shared_o.addr  = dma_sel_q ? dma_i.addr  : core_i.addr;
  assign shared_o.wdata = dma_sel_q ? dma_i.wdata : core_i.wdata;
  assign shared_o.wstrb = dma_sel_q ? dma_i.wstrb : core_i.wstrb;

  // response back to the granted master only
  assign core_i.ready = grant_core && shared_o.ready;
  assign core_i.rdata = grant_core ? shared_o.rdata : '0;
  assign dma_i.ready  = grant_dma && shared_o.ready;
  assign dma_i.rdata  = grant_dma ? shared_o.rdata : '0;

endmodule

// File: nmi_if.sv
/*
 * native memory interface
 * single word valid/ready transfer, zero wstrb means a read
 */

`timescale 1ns/1ps

interface nmi_if;
  import bus_pkg::*;

  logic              valid;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              ready;
  logic [DATA_W-1:0] rdata;

  modport master(
    output valid, addr, wdata, wstrb,
    input  ready, rdata
  );

  modport slave(
    input  valid, addr, wdata, wstrb,
    output ready, rdata
  );

endinterface

// File: bus_pkg.sv
/*
 * system bus package
 * memory map, bus widths, scratch RAM depth, error word,
 * and the slice state and decoded target enums
 */

package bus_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // scratch RAM geometry, word addressed
  localparam int RAM_WORDS = 256;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  // memory map, top address byte of each region
  localparam logic [7:0] RAM_BASE   = 8'h00;
  localparam logic [7:0] NATV_BASE  = 8'h10;
  localparam logic [7:0] APB_BASE   = 8'h20;
  // flash sits behind the APB bridge
  localparam logic [7:0] FLASH_BASE = 8'h30;

  // read data for addresses that no target claims
  localparam logic [DATA_W-1:0] ERR_WORD = 32'hDEAD_BEEF;

  // register slice controller
  typedef enum logic [1:0] {
    SL_IDLE = 2'd0,
    SL_BUSY = 2'd1,
    SL_RESP = 2'd2
  } slice_state_e;

  // decoded target of the current transfer
  typedef enum logic [1:0] {
    TGT_RAM  = 2'd0,
    TGT_NATV = 2'd1,
    TGT_APB  = 2'd2,
    TGT_NONE = 2'd3
  } target_e;

endpackage
